// ==== Bender.yml ====
package:
  name: vfpu

sources:
  - design/flp_pkg.sv
  - design/vfpu_pkg.sv
  - design/vfpu_lane_if.sv
  - design/flp_unpack.sv
  - design/flp_lane.sv
  - design/vfpu_issue.sv
  - design/vfpu_collect.sv
  - design/vfpu_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/tb_vfpu.sv

// ==== all.f ====
design/flp_pkg.sv
design/vfpu_pkg.sv
design/vfpu_lane_if.sv
design/flp_unpack.sv
design/flp_lane.sv
design/vfpu_issue.sv
design/vfpu_collect.sv
design/vfpu_top.sv
sim/tb_clkgen.sv
sim/tb_vfpu.sv

// ==== design/flp_lane.sv ====
// One vector lane: FMUL, FMIN and FMAX over two pipeline stages.
// Stage 1 unpacks and computes, stage 2 normalizes and packs.
`timescale 1ns/100ps

module flp_lane
  import flp_pkg::*;
  import vfpu_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_arst_n,
  vfpu_lane_if.lane lane
);

  // Result kind chosen in stage 1.
  typedef enum logic [2:0] {
    K_ZERO,
    K_INF,
    K_QNAN,
    K_PASS,
    K_PROD
  } res_kind_e;

  flp_unpacked_t ua;
  flp_unpacked_t ub;

  // Stage 1 next-state values.
  res_kind_e                   kind_d;
  logic                        sign_d;
  logic                        nv_d;
  logic [FLP_WIDTH-1:0]        pass_d;
  logic [2*FLP_SWIDTH+1:0]     prod_d;
  logic signed [FLP_EWIDTH+1:0] exp_d;

  // Operand ordering helpers.
  logic                        sa;
  logic                        sb;
  logic [FLP_WIDTH-2:0]        mag_a;
  logic [FLP_WIDTH-2:0]        mag_b;
  logic                        a_lt_b;
  logic                        b_lt_a;
  logic [FLP_WIDTH-1:0]        pack_a;
  logic [FLP_WIDTH-1:0]        pack_b;

  // Stage 1 registers.
  logic                        s1_valid;
  res_kind_e                   s1_kind;
  logic                        s1_sign;
  logic                        s1_nv;
  logic [FLP_WIDTH-1:0]        s1_pass;
  logic [2*FLP_SWIDTH+1:0]     s1_prod;
  logic signed [FLP_EWIDTH+1:0] s1_exp;

  // Stage 2 next-state values.
  logic signed [FLP_EWIDTH+1:0] norm_exp;
  logic [FLP_SWIDTH-1:0]       norm_sig;
  logic [FLP_WIDTH-1:0]        res_d;

  // Stage 2 registers.
  logic                        s2_valid;
  logic [FLP_WIDTH-1:0]        s2_res;
  logic                        s2_nv;

  flp_unpack u_unpack_a (.i_fpd(lane.req_a), .o_unp(ua));
  flp_unpack u_unpack_b (.i_fpd(lane.req_b), .o_unp(ub));

  // Repacked operands, subnormals flushed to signed zero.
  assign pack_a = {ua.sign, ua.exp, ua.sig[FLP_SWIDTH-1:0]};
  assign pack_b = {ub.sign, ub.exp, ub.sig[FLP_SWIDTH-1:0]};

  // Zeros compare as positive, so all zeros tie.
  assign sa    = ua.sign & ~ua.zero;
  assign sb    = ub.sign & ~ub.zero;
  assign mag_a = pack_a[FLP_WIDTH-2:0];
  assign mag_b = pack_b[FLP_WIDTH-2:0];
  // Negative magnitudes order in reverse.
  assign a_lt_b = (sa & ~sb) | (~sa & ~sb & (mag_a < mag_b)) | (sa & sb & (mag_a > mag_b));
  assign b_lt_a = (sb & ~sa) | (~sa & ~sb & (mag_b < mag_a)) | (sa & sb & (mag_b > mag_a));

  // Stage 1 special-case selection.
  always_comb begin
    kind_d = K_ZERO;
    sign_d = 1'b0;
    nv_d   = 1'b0;
    pass_d = pack_a;
    prod_d = ua.sig * ub.sig;
    // Biased sum wraps into a signed value.
    exp_d  = (FLP_EWIDTH+2)'(ua.exp) + (FLP_EWIDTH+2)'(ub.exp) - (FLP_EWIDTH+2)'(FLP_BIAS);
    if (lane.req_en) begin
      case (lane.req_op)
        OP_FMUL: begin
          sign_d = ua.sign ^ ub.sign;
          if (ua.nan | ub.nan | (ua.zero & ub.inf) | (ua.inf & ub.zero)) begin
            kind_d = K_QNAN;
            nv_d   = 1'b1;
          end else if (ua.inf | ub.inf) begin
            kind_d = K_INF;
          end else if (ua.zero | ub.zero) begin
            kind_d = K_ZERO;
          end else begin
            kind_d = K_PROD;
          end
        end
        OP_FMIN, OP_FMAX: begin
          kind_d = K_PASS;
          if (ua.nan & ub.nan) begin
            kind_d = K_QNAN;
            nv_d   = 1'b1;
          end else if (ua.nan) begin
            pass_d = pack_b;
          end else if (ub.nan) begin
            pass_d = pack_a;
          end else if (lane.req_op == OP_FMIN) begin
            // Ties keep operand a.
            pass_d = b_lt_a ? pack_b : pack_a;
          end else begin
            pass_d = a_lt_b ? pack_b : pack_a;
          end
        end
        // NOP falls through as an unsigned zero.
        default: kind_d = K_ZERO;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= lane.req_valid;
    end
  end

  // Stage 1 payload, loaded only on a request.
  always_ff @(posedge i_clk) begin
    if (lane.req_valid) begin
      s1_kind <= kind_d;
      s1_sign <= sign_d;
      s1_nv   <= nv_d;
      s1_pass <= pass_d;
      s1_prod <= prod_d;
      s1_exp  <= exp_d;
    end
  end

  // Stage 2 normalize, saturate and pack.
  always_comb begin
    norm_exp = s1_exp;
    norm_sig = s1_prod[2*FLP_SWIDTH-1:FLP_SWIDTH];
    // Product in [2,4) needs one right shift.
    if (s1_prod[2*FLP_SWIDTH+1]) begin
      norm_exp = s1_exp + 1;
      norm_sig = s1_prod[2*FLP_SWIDTH:FLP_SWIDTH+1];
    end
    case (s1_kind)
      K_QNAN:  res_d = FLP_QNAN;
      K_INF:   res_d = {s1_sign, {FLP_EWIDTH{1'b1}}, {FLP_SWIDTH{1'b0}}};
      K_PASS:  res_d = s1_pass;
      K_PROD: begin
        if (norm_exp >= 255) begin
          // Overflow saturates.
          res_d = {s1_sign, {FLP_EWIDTH{1'b1}}, {FLP_SWIDTH{1'b0}}};
        end else if (norm_exp <= 0) begin
          // Underflow flushes.
          res_d = {s1_sign, {(FLP_WIDTH-1){1'b0}}};
        end else begin
          res_d = {s1_sign, norm_exp[FLP_EWIDTH-1:0], norm_sig};
        end
      end
      default: res_d = {s1_sign, {(FLP_WIDTH-1){1'b0}}};
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      s2_res <= res_d;
      s2_nv  <= s1_nv;
    end
  end

  assign lane.res_valid = s2_valid;
  assign lane.res       = s2_res;
  assign lane.res_nv    = s2_nv;

endmodule

// ==== design/flp_pkg.sv ====
// Single-precision format constants and the unpacked operand type.
package flp_pkg;

  // Exponent width.
  localparam int FLP_EWIDTH = 8;
  // Stored significand width, hidden one excluded.
  localparam int FLP_SWIDTH = 23;
  // Packed word width.
  localparam int FLP_WIDTH = FLP_EWIDTH + FLP_SWIDTH + 1;
  // Exponent bias.
  localparam int FLP_BIAS = 127;

  // Canonical quiet NaN.
  // All NaN results use this one encoding.
  localparam logic [FLP_WIDTH-1:0] FLP_QNAN = 32'h7FC0_0000;

  // Operand after field split and classification.
  // Significand carries the hidden one, or is zero for zero and subnormal inputs.
  typedef struct packed {
    logic                  sign;
    logic [FLP_EWIDTH-1:0] exp;
    logic [FLP_SWIDTH:0]   sig;
    logic                  zero;
    logic                  nan;
    logic                  inf;
  } flp_unpacked_t;

endpackage

// ==== design/flp_unpack.sv ====
// Packed float field split with zero, NaN and infinity classification.
`timescale 1ns/100ps

module flp_unpack
  import flp_pkg::*;
(
  input  logic [FLP_WIDTH-1:0] i_fpd,
  output flp_unpacked_t        o_unp
);

  logic                  sign;
  logic [FLP_EWIDTH-1:0] exp;
  logic [FLP_SWIDTH-1:0] frac;
  logic                  exp_zero;
  logic                  exp_ones;
  logic                  frac_nz;

  // Field extraction.
  assign sign = i_fpd[FLP_WIDTH-1];
  assign exp  = i_fpd[FLP_WIDTH-2:FLP_SWIDTH];
  assign frac = i_fpd[FLP_SWIDTH-1:0];

  // Exponent extremes.
  assign exp_zero = ~(|exp);
  assign exp_ones = &exp;
  // Stored fraction non-zero.
  assign frac_nz = |frac;

  always_comb begin
    o_unp.sign = sign;
    o_unp.exp  = exp;
    // Subnormals read as zero.
    // Their significand is dropped with the hidden one.
    o_unp.sig  = exp_zero ? '0 : {1'b1, frac};
    o_unp.zero = exp_zero;
    // All-ones exponent splits on the fraction.
    o_unp.nan  = exp_ones & frac_nz;
    o_unp.inf  = exp_ones & ~frac_nz;
  end

endmodule

// ==== design/vfpu_collect.sv ====
// Output register for lane results, per-lane invalid and the sticky flag.
`timescale 1ns/100ps

module vfpu_collect
  import flp_pkg::*;
  import vfpu_pkg::*;
(
  input  logic                                  i_clk,
  input  logic                                  i_arst_n,
  input  logic                                  i_clr_nv,
  vfpu_lane_if.collect                          lanes [VFPU_NLANES],
  output logic                                  o_valid,
  output logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] o_res,
  output logic [VFPU_NLANES-1:0]                o_nv,
  output logic                                  o_nv_sticky
);

  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] res_w;
  logic [VFPU_NLANES-1:0]                nv_w;
  logic                                  valid_w;

  // Gather lane outputs into flat vectors.
  for (genvar g = 0; g < VFPU_NLANES; g++) begin : g_gather
    assign res_w[g] = lanes[g].res;
    assign nv_w[g]  = lanes[g].res_nv;
  end

  // Lanes run in lockstep.
  // Lane 0 speaks for all of them.
  assign valid_w = lanes[0].res_valid;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid     <= 1'b0;
      o_res       <= '0;
      o_nv        <= '0;
      o_nv_sticky <= 1'b0;
    end else begin
      o_valid <= valid_w;
      if (valid_w) begin
        o_res <= res_w;
        o_nv  <= nv_w;
      end
      // New invalid wins over a clear.
      o_nv_sticky <= (o_nv_sticky & ~i_clr_nv) | (valid_w & (|nv_w));
    end
  end

endmodule

// ==== design/vfpu_issue.sv ====
// Issue register: opcode decode, lane mask and operand fan-out.
`timescale 1ns/100ps

module vfpu_issue
  import flp_pkg::*;
  import vfpu_pkg::*;
(
  input  logic                                  i_clk,
  input  logic                                  i_arst_n,
  input  logic                                  i_valid,
  input  vfpu_op_e                              i_op,
  input  logic [VFPU_NLANES-1:0]                i_mask,
  input  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] i_a,
  input  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] i_b,
  vfpu_lane_if.issue                            lanes [VFPU_NLANES]
);

  logic                                  valid_q;
  vfpu_op_e                              op_d;
  vfpu_op_e                              op_q;
  logic [VFPU_NLANES-1:0]                mask_q;
  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] a_q;
  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] b_q;

  // Unknown encodings become NOP.
  always_comb begin
    case (i_op)
      OP_FMUL: op_d = OP_FMUL;
      OP_FMIN: op_d = OP_FMIN;
      OP_FMAX: op_d = OP_FMAX;
      default: op_d = OP_NOP;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
      op_q    <= OP_NOP;
      mask_q  <= '0;
    end else begin
      valid_q <= i_valid;
      if (i_valid) begin
        op_q   <= op_d;
        mask_q <= i_mask;
      end
    end
  end

  // Operand payload.
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  // One operand pair per lane.
  // Mask bit gates the lane's result, not its valid.
  for (genvar g = 0; g < VFPU_NLANES; g++) begin : g_fan
    assign lanes[g].req_valid = valid_q;
    assign lanes[g].req_en    = mask_q[g];
    assign lanes[g].req_op    = op_q;
    assign lanes[g].req_a     = a_q[g];
    assign lanes[g].req_b     = b_q[g];
  end

endmodule

// ==== design/vfpu_lane_if.sv ====
// Per-lane request and result bundle with issue, lane and collect modports.
`timescale 1ns/100ps

interface vfpu_lane_if
  import flp_pkg::*;
  import vfpu_pkg::*;
  ();

  // Request side, from the issue register.
  logic                 req_valid;
  logic                 req_en;
  vfpu_op_e             req_op;
  logic [FLP_WIDTH-1:0] req_a;
  logic [FLP_WIDTH-1:0] req_b;

  // Result side, from the lane's last stage.
  logic                 res_valid;
  logic [FLP_WIDTH-1:0] res;
  logic                 res_nv;

  // Issue block drives requests.
  modport issue (output req_valid, req_en, req_op, req_a, req_b);

  // Lane consumes a request and returns a result.
  modport lane (
    input  req_valid, req_en, req_op, req_a, req_b,
    output res_valid, res, res_nv
  );

  // Collector only sees results.
  modport collect (input res_valid, res, res_nv);

endinterface

// ==== design/vfpu_pkg.sv ====
// Vector unit configuration: lane count, opcodes and pipeline latency.
package vfpu_pkg;

  // Number of parallel lanes.
  // Each lane takes one operand pair per request.
  localparam int VFPU_NLANES = 4;

  // Lane operations.
  // NOP still produces a result word, all zero.
  typedef enum logic [1:0] {
    OP_FMUL = 2'd0,
    OP_FMIN = 2'd1,
    OP_FMAX = 2'd2,
    OP_NOP  = 2'd3
  } vfpu_op_e;

  // Request to result, in clock edges.
  // Issue register, two lane stages, collect register.
  localparam int VFPU_LATENCY = 4;

endpackage

// ==== design/vfpu_top.sv ====
// Vector FPU top: issue register, lane array and result collector.
`timescale 1ns/100ps

module vfpu_top
  import flp_pkg::*;
  import vfpu_pkg::*;
(
  input  logic                                  i_clk,
  input  logic                                  i_arst_n,
  input  logic                                  i_valid,
  input  vfpu_op_e                              i_op,
  input  logic [VFPU_NLANES-1:0]                i_mask,
  input  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] i_a,
  input  logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] i_b,
  input  logic                                  i_clr_nv,
  output logic                                  o_valid,
  output logic [VFPU_NLANES-1:0][FLP_WIDTH-1:0] o_res,
  output logic [VFPU_NLANES-1:0]                o_nv,
  output logic                                  o_nv_sticky
);

  // One bundle per lane.
  vfpu_lane_if lane_if [VFPU_NLANES] ();

  vfpu_issue u_issue (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_valid (i_valid),
    .i_op    (i_op),
    .i_mask  (i_mask),
    .i_a     (i_a),
    .i_b     (i_b),
    .lanes   (lane_if)
  );

  // Identical lanes.
  for (genvar g = 0; g < VFPU_NLANES; g++) begin : g_lane
    flp_lane u_lane (
      .i_clk   (i_clk),
      .i_arst_n(i_arst_n),
      .lane    (lane_if[g])
    );
  end

  vfpu_collect u_collect (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_clr_nv   (i_clr_nv),
    .lanes      (lane_if),
    .o_valid    (o_valid),
    .o_res      (o_res),
    .o_nv       (o_nv),
    .o_nv_sticky(o_nv_sticky)
  );

endmodule

// ==== sim/tb_clkgen.sv ====
// Testbench clock and active-low reset source.
`timescale 1ns/100ps

module tb_clkgen (
  output logic o_clk,
  output logic o_arst_n
);

  // 10 ns period.
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset low for two rising edges.
  // Released on a falling edge, away from the sampling edge.
  initial begin
    o_arst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule

// ==== sim/tb_vfpu.sv ====
// Vector FPU testbench: directed table, lane reference model, random pipelined phase.
`timescale 1ns/100ps

module tb_vfpu
  import flp_pkg::*;
  import vfpu_pkg::*;
();

  localparam int VW      = VFPU_NLANES * FLP_WIDTH;
  localparam int TIMEOUT = 4 * VFPU_LATENCY;
  localparam int NRAND   = 24;

  // One request plus hand-derived lane 0 result.
  typedef struct packed {
    vfpu_op_e               op;
    logic [VFPU_NLANES-1:0] mask;
    logic                   clr;
    logic [FLP_WIDTH-1:0]   exp0;
    logic [VW-1:0]          a;
    logic [VW-1:0]          b;
  } row_t;

  logic                   i_clk;
  logic                   i_arst_n;
  logic                   i_valid;
  vfpu_op_e               i_op;
  logic [VFPU_NLANES-1:0] i_mask;
  logic [VW-1:0]          i_a;
  logic [VW-1:0]          i_b;
  logic                   i_clr_nv;
  logic                   o_valid;
  logic [VW-1:0]          o_res;
  logic [VFPU_NLANES-1:0] o_nv;
  logic                   o_nv_sticky;

  row_t                   rows [$];
  string                  names [$];
  logic [VW-1:0]          exp_res_q [$];
  logic [VFPU_NLANES-1:0] exp_nv_q [$];
  int                     seed;
  int                     n_tests;
  int                     n_pass;
  int                     n_fail;
  int                     n_err;
  logic                   sticky_exp;

  tb_clkgen u_clkgen (.o_clk(i_clk), .o_arst_n(i_arst_n));

  vfpu_top i_dut (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_mask     (i_mask),
    .i_a        (i_a),
    .i_b        (i_b),
    .i_clr_nv   (i_clr_nv),
    .o_valid    (o_valid),
    .o_res      (o_res),
    .o_nv       (o_nv),
    .o_nv_sticky(o_nv_sticky)
  );

  // Subnormals read as signed zero.
  function automatic logic [31:0] flush_sub(input logic [31:0] x);
    return (x[30:23] == 8'h00) ? {x[31], 31'h0} : x;
  endfunction

  // Signed ordering key; every zero maps to 0.
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = $signed({2'b00, x[30:0]});
    if (x[30:23] == 8'h00) return '0;
    return x[31] ? -mag : mag;
  endfunction

  // Reference lane result, {nv, word}.
  function automatic logic [32:0] lane_model(input vfpu_op_e op, input logic en,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] fa;
    logic [31:0] fb;
    logic        an;
    logic        bn;
    logic        ai;
    logic        bi;
    logic        az;
    logic        bz;
    logic        s;
    logic [47:0] prod;
    int          e;
    logic [22:0] m;
    fa = flush_sub(a);
    fb = flush_sub(b);
    an = (a[30:23] == 8'hFF) && (a[22:0] != 23'h0);
    bn = (b[30:23] == 8'hFF) && (b[22:0] != 23'h0);
    ai = (a[30:23] == 8'hFF) && (a[22:0] == 23'h0);
    bi = (b[30:23] == 8'hFF) && (b[22:0] == 23'h0);
    az = (a[30:23] == 8'h00);
    bz = (b[30:23] == 8'h00);
    s  = a[31] ^ b[31];
    if (!en || op == OP_NOP) return '0;
    if (op == OP_FMUL) begin
      if (an || bn || (az && bi) || (ai && bz)) return {1'b1, FLP_QNAN};
      if (ai || bi) return {1'b0, s, 8'hFF, 23'h0};
      if (az || bz) return {1'b0, s, 31'h0};
      prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};
      e = int'(a[30:23]) + int'(b[30:23]) - FLP_BIAS;
      // Product in [2,4) moves the point by one.
      if (prod[47]) begin
        e = e + 1;
        m = prod[46:24];
      end else begin
        m = prod[45:23];
      end
      if (e >= 255) return {1'b0, s, 8'hFF, 23'h0};
      if (e <= 0) return {1'b0, s, 31'h0};
      return {1'b0, s, e[7:0], m};
    end
    if (an && bn) return {1'b1, FLP_QNAN};
    if (an) return {1'b0, fb};
    if (bn) return {1'b0, fa};
    // Ties keep a.
    if (op == OP_FMIN) return {1'b0, (order_key(fb) < order_key(fa)) ? fb : fa};
    return {1'b0, (order_key(fb) > order_key(fa)) ? fb : fa};
  endfunction

  // Expected words for all lanes.
  task automatic expect_row(input row_t r, output logic [VW-1:0] res,
                            output logic [VFPU_NLANES-1:0] nv);
    logic [32:0] lr;
    for (int k = 0; k < VFPU_NLANES; k++) begin
      lr = lane_model(r.op, r.mask[k], r.a[k*FLP_WIDTH +: FLP_WIDTH],
                      r.b[k*FLP_WIDTH +: FLP_WIDTH]);
      res[k*FLP_WIDTH +: FLP_WIDTH] = lr[31:0];
      nv[k] = lr[32];
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      n_err++;
      ok = 1'b0;
    end
  endtask

  // Full output word, per-lane nv and the sticky flag.
  task automatic check_out(input logic [VW-1:0] res, input logic [VFPU_NLANES-1:0] nv,
                           input logic sticky, inout bit ok);
    for (int k = 0; k < VFPU_NLANES; k++) begin
      check_word($sformatf("o_res[%0d]", k), o_res[k*FLP_WIDTH +: FLP_WIDTH],
                 res[k*FLP_WIDTH +: FLP_WIDTH], ok);
    end
    check_word("o_nv", o_nv, nv, ok);
    check_word("o_nv_sticky", o_nv_sticky, sticky, ok);
  endtask

  // Polls o_valid on falling edges, bounded.
  task automatic wait_valid(output bit seen);
    int cyc;
    cyc = 0;
    while (o_valid !== 1'b1 && cyc < TIMEOUT) begin
      @(negedge i_clk);
      cyc++;
    end
    seen = (o_valid === 1'b1);
    assert (seen) else begin
      $display("o_valid never came within %0d cycles at %0t", TIMEOUT, $time);
      n_err++;
    end
  endtask

  task automatic report(input string name, input bit ok);
    n_tests++;
    if (ok) n_pass++;
    else n_fail++;
    $display("test %0d %s: %s", n_tests, name, ok ? "ok" : "failed");
  endtask

  task automatic add_row(input string name, input vfpu_op_e op, input logic [3:0] mask,
                         input logic clr, input logic [31:0] exp0,
                         input logic [VW-1:0] a, input logic [VW-1:0] b);
    row_t r;
    r.op   = op;
    r.mask = mask;
    r.clr  = clr;
    r.exp0 = exp0;
    r.a    = a;
    r.b    = b;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Lanes listed {3, 2, 1, 0}.
  task automatic load_table();
    add_row("fmul normal", OP_FMUL, 4'hF, 1'b0, 32'h4040_0000,
            {32'h0080_0000, 32'h7F00_0000, 32'h3FAA_AAAB, 32'h3FC0_0000},
            {32'h3F00_0000, 32'h4000_0000, 32'h3FAA_AAAB, 32'h4000_0000});
    add_row("fmul sign subnormal", OP_FMUL, 4'hF, 1'b0, 32'hC040_0000,
            {32'h3FFF_FFFF, 32'hBF80_0000, 32'h8000_0001, 32'hC000_0000},
            {32'h3FFF_FFFF, 32'h7F7F_FFFF, 32'h3F80_0000, 32'h3FC0_0000});
    add_row("fmul special", OP_FMUL, 4'hF, 1'b0, 32'h7FC0_0000,
            {32'h8000_0000, 32'hFF80_0000, 32'h0000_0000, 32'h7FC0_0000},
            {32'h4040_0000, 32'h4000_0000, 32'h7F80_0000, 32'h3F80_0000});
    add_row("fmin order", OP_FMIN, 4'hF, 1'b0, 32'hC000_0000,
            {32'h0000_0000, 32'hC080_0000, 32'h4080_0000, 32'hC000_0000},
            {32'h8000_0000, 32'hC000_0000, 32'h4000_0000, 32'h3F80_0000});
    add_row("fmax nan pass", OP_FMAX, 4'hF, 1'b0, 32'h3F80_0000,
            {32'h8000_0000, 32'hBF80_0000, 32'h7FC0_0000, 32'h3F80_0000},
            {32'h0000_0005, 32'h7F80_0001, 32'h4000_0000, 32'hFF80_0000});
    add_row("fmax double nan", OP_FMAX, 4'hF, 1'b0, 32'h7FC0_0000,
            {32'h4000_0000, 32'h4000_0000, 32'h4000_0000, 32'h7FC0_0000},
            {32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h7F80_0001});
    add_row("fmin sticky clear", OP_FMIN, 4'hF, 1'b1, 32'h3F80_0000,
            {32'h4000_0000, 32'hC000_0000, 32'h0000_0003, 32'h3F80_0000},
            {32'h4000_0001, 32'hC000_0000, 32'h8000_0000, 32'h3F80_0000});
    add_row("fmul lane mask", OP_FMUL, 4'b1010, 1'b0, 32'h0000_0000,
            {32'h4000_0000, 32'h7FC0_0000, 32'h7FC0_0000, 32'h7FC0_0000},
            {32'h4000_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h7FC0_0000});
    add_row("nop", OP_NOP, 4'hF, 1'b0, 32'h0000_0000,
            {4{32'h7FC0_0000}}, {4{32'h0000_0000}});
    add_row("all masked clear", OP_FMUL, 4'h0, 1'b1, 32'h0000_0000,
            {4{32'h7FC0_0000}}, {4{32'h7F80_0000}});
  endtask

  // Random operand, biased toward special encodings.
  function automatic logic [31:0] pick_operand(input logic [31:0] r);
    case (r[3:0])
      4'd0: return FLP_QNAN;
      4'd1: return {r[31], 8'hFF, 23'h0};
      4'd2: return {r[31], 31'h0};
      4'd3: return {r[31], 8'h00, r[22:0]};
      4'd4: return {r[31], 8'hFF, r[22:1], 1'b1};
      4'd5, 4'd6: return r;
      default: return {r[31], 8'd96 + {2'b00, r[29:24]}, r[22:0]};
    endcase
  endfunction

  function automatic vfpu_op_e pick_op(input logic [1:0] code);
    case (code)
      2'd0: return OP_FMUL;
      2'd1: return OP_FMIN;
      2'd2: return OP_FMAX;
      default: return OP_NOP;
    endcase
  endfunction

  initial begin
    logic [VW-1:0]          res_e;
    logic [VFPU_NLANES-1:0] nv_e;
    row_t                   r;
    bit                     ok;
    bit                     seen;
    int                     cyc;
    int                     extra;
    seed       = 32'h411c89e4;
    i_valid    = 1'b0;
    i_op       = OP_NOP;
    i_mask     = '0;
    i_a        = '0;
    i_b        = '0;
    i_clr_nv   = 1'b0;
    n_tests    = 0;
    n_pass     = 0;
    n_fail     = 0;
    n_err      = 0;
    sticky_exp = 1'b0;
    load_table();

    // Reset release, bounded.
    cyc = 0;
    while (i_arst_n !== 1'b1 && cyc < TIMEOUT) begin
      @(negedge i_clk);
      cyc++;
    end
    assert (i_arst_n === 1'b1) else begin
      $display("reset was never released");
      n_err++;
    end
    @(negedge i_clk);
    ok = 1'b1;
    check_word("o_valid", o_valid, 32'h0, ok);
    check_word("o_nv", o_nv, 32'h0, ok);
    check_word("o_nv_sticky", o_nv_sticky, 32'h0, ok);
    report("reset state", ok);

    // Directed rows, one request in flight.
    foreach (rows[i]) begin
      r = rows[i];
      @(negedge i_clk);
      i_valid  = 1'b1;
      i_op     = r.op;
      i_mask   = r.mask;
      i_a      = r.a;
      i_b      = r.b;
      i_clr_nv = r.clr;
      @(negedge i_clk);
      i_valid  = 1'b0;
      i_clr_nv = 1'b0;
      expect_row(r, res_e, nv_e);
      // Clear lands before this row's result.
      sticky_exp = (sticky_exp & ~r.clr) | (|nv_e);
      ok = 1'b1;
      wait_valid(seen);
      if (seen) begin
        check_word("o_res[0] table", o_res[FLP_WIDTH-1:0], r.exp0, ok);
        check_out(res_e, nv_e, sticky_exp, ok);
      end else begin
        ok = 1'b0;
      end
      report(names[i], ok);
    end

    // Back-to-back random requests.
    fork
      begin : drive
        row_t                   rr;
        logic [VW-1:0]          dres;
        logic [VFPU_NLANES-1:0] dnv;
        for (int n = 0; n < NRAND; n++) begin
          @(negedge i_clk);
          rr.op   = pick_op($random(seed));
          rr.mask = $random(seed);
          rr.clr  = 1'b0;
          rr.exp0 = '0;
          for (int k = 0; k < VFPU_NLANES; k++) begin
            rr.a[k*FLP_WIDTH +: FLP_WIDTH] = pick_operand($random(seed));
            rr.b[k*FLP_WIDTH +: FLP_WIDTH] = pick_operand($random(seed));
          end
          i_valid = 1'b1;
          i_op    = rr.op;
          i_mask  = rr.mask;
          i_a     = rr.a;
          i_b     = rr.b;
          expect_row(rr, dres, dnv);
          exp_res_q.push_back(dres);
          exp_nv_q.push_back(dnv);
        end
        @(negedge i_clk);
        i_valid = 1'b0;
      end
      begin : monitor
        logic [VW-1:0]          cres;
        logic [VFPU_NLANES-1:0] cnv;
        bit                     cok;
        bit                     cseen;
        @(negedge i_clk);
        for (int n = 0; n < NRAND; n++) begin
          cok = 1'b1;
          wait_valid(cseen);
          if (!cseen) begin
            cok = 1'b0;
          end else if (exp_res_q.size() == 0) begin
            $display("o_valid came with no request in flight at %0t", $time);
            n_err++;
            cok = 1'b0;
          end else begin
            cres = exp_res_q.pop_front();
            cnv  = exp_nv_q.pop_front();
            sticky_exp = sticky_exp | (|cnv);
            check_out(cres, cnv, sticky_exp, cok);
          end
          report($sformatf("random %0d", n), cok);
          @(negedge i_clk);
        end
      end
    join

    // No stray pulses, nothing left over.
    extra = 0;
    for (cyc = 0; cyc < TIMEOUT; cyc++) begin
      @(negedge i_clk);
      if (o_valid === 1'b1) extra++;
    end
    ok = 1'b1;
    assert (extra == 0 && exp_res_q.size() == 0) else begin
      $display("%0d extra o_valid pulses, %0d results never came", extra, exp_res_q.size());
      n_err++;
      ok = 1'b0;
    end
    report("pipeline pulse count", ok);

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             n_tests, n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
